// ==== src/fbdev_defines.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Display mode, FIFO depth and bus width settings.
// Include in every file that needs a mode value.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FBDEV_DEFINES_SVH
`define FBDEV_DEFINES_SVH

`define FB_WIDTH   640
`define FB_HEIGHT  480
`define FB_REFRESH 60

// Mode table: 640x480@60, 800x600@72, 1280x720@60, 1920x1080@60.
`define FB_H_SYNC_START ((`FB_WIDTH == 640) ? 656 : (`FB_WIDTH == 800) ? 856 : \
	(`FB_WIDTH == 1280) ? 1390 : 2008)
`define FB_H_SYNC_END   ((`FB_WIDTH == 640) ? 752 : (`FB_WIDTH == 800) ? 976 : \
	(`FB_WIDTH == 1280) ? 1430 : 2052)
`define FB_H_MAX        ((`FB_WIDTH == 640) ? 800 : (`FB_WIDTH == 800) ? 1040 : \
	(`FB_WIDTH == 1280) ? 1650 : 2200)
`define FB_V_SYNC_START ((`FB_HEIGHT == 480) ? 490 : (`FB_HEIGHT == 600) ? 637 : \
	(`FB_HEIGHT == 720) ? 725 : 1084)
`define FB_V_SYNC_END   ((`FB_HEIGHT == 480) ? 492 : (`FB_HEIGHT == 600) ? 643 : \
	(`FB_HEIGHT == 720) ? 730 : 1089)
`define FB_V_MAX        ((`FB_HEIGHT == 480) ? 525 : (`FB_HEIGHT == 600) ? 666 : \
	(`FB_HEIGHT == 720) ? 750 : 1125)

`define FB_BUFSZ   16 // Words, power of two.
`define FB_FREE_W  ($clog2(`FB_BUFSZ) + 1)
`define FB_ADDR_W  30
`define FB_BUFCNT  1

`endif

// ==== src/fbdev_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus opcodes, host commands and pixel word types.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fbdev_pkg;

	// Opcodes shared by the host port and the memory bus.
	typedef enum logic [1:0] {
		PINOOP = 2'b00,
		PIWROP = 2'b01,
		PIRDOP = 2'b10,
		PIRWOP = 2'b11
	} pi_op_e;

	// Command code in bits 1:0 of a command word.
	typedef enum logic [1:0] {
		CMDSRCSET  = 2'd0,
		CMDGETINFO = 2'd1
	} cmd_e;

	// Selector in bits 31:2 of a CMDGETINFO word.
	typedef enum logic [29:0] {
		GETINFO_WIDTH  = 30'd0,
		GETINFO_HEIGHT = 30'd1,
		GETINFO_HZ     = 30'd2,
		GETINFO_BUFCNT = 30'd3
	} getinfo_e;

	// One run-length pixel word as stored in memory.
	typedef struct packed {
		logic [7:0] rpt;   // Shown rpt+1 times.
		logic [7:0] blue;
		logic [7:0] green;
		logic [7:0] red;
	} px_word_t;

	// Pixels per frame, up to 1920x1080.
	typedef logic [20:0] px_cnt_t;

endpackage

// ==== src/vid_timing_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster flags from the timing generator to the expander.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface vid_timing_if;
	logic       active;    // Position is in the visible area.
	logic       vblank;
	logic       frame_end; // Last visible pixel.
	logic       blank_q;
	logic [1:0] sync_q;    // {vsync, hsync}.

	modport source (output active, output vblank, output frame_end,
		output blank_q, output sync_q);

	modport sink (input active, input vblank, input frame_end,
		input blank_q, input sync_q);
endinterface

// ==== src/video_timing.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster counters with registered blank and sync.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

`include "fbdev_defines.svh"

module video_timing (
	input  logic          clk_i,
	input  logic          vga_rst_o,
	vid_timing_if.source  tim
);
	logic [11:0] h_q;
	logic [11:0] v_q;
	logic        h_last;
	logic        v_last;
	logic        blank;
	logic        hsync;
	logic        vsync;

	assign h_last = (h_q == 12'(`FB_H_MAX - 1));
	assign v_last = (v_q == 12'(`FB_V_MAX - 1));

	always_ff @(posedge clk_i) begin
		if (vga_rst_o) begin
			h_q <= '0;
			v_q <= '0;
		end else if (h_last) begin
			h_q <= '0;
			v_q <= v_last ? 12'd0 : v_q + 12'd1;
		end else begin
			h_q <= h_q + 12'd1;
		end
	end

	assign blank = (h_q >= `FB_WIDTH) || (v_q >= `FB_HEIGHT);
	assign hsync = (h_q >= `FB_H_SYNC_START) && (h_q < `FB_H_SYNC_END);
	assign vsync = (v_q >= `FB_V_SYNC_START) && (v_q < `FB_V_SYNC_END);

	assign tim.active    = !blank;
	assign tim.vblank    = (v_q >= `FB_HEIGHT);
	assign tim.frame_end = (h_q == 12'(`FB_WIDTH - 1)) && (v_q == 12'(`FB_HEIGHT - 1));

	// Outputs lag the counters by one cycle.
	always_ff @(posedge clk_i) begin
		if (vga_rst_o) begin
			tim.blank_q <= 1'b0;
			tim.sync_q  <= 2'b00;
		end else begin
			tim.blank_q <= blank;
			tim.sync_q  <= {vsync, hsync};
		end
	end

	a_h_range: assert property (@(posedge clk_i) disable iff (vga_rst_o)
		h_q < 12'(`FB_H_MAX));
endmodule

// ==== src/pixel_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel word FIFO between the fetcher and the expander.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

`include "fbdev_defines.svh"

module pixel_fifo (
	input  logic                    clk_i,
	input  logic                    vga_rst_o,
	input  logic                    push_valid_i,
	input  fbdev_pkg::px_word_t     push_data_i,
	output logic [`FB_FREE_W-1:0]   free_o,
	output logic                    pop_valid_o,
	input  logic                    pop_ready_i,
	output fbdev_pkg::px_word_t     pop_data_o
);
	import fbdev_pkg::*;

	localparam int AW = $clog2(`FB_BUFSZ);
	localparam int CW = `FB_FREE_W;
	localparam logic [CW-1:0] DEPTH = CW'(`FB_BUFSZ);

	px_word_t        mem_q [`FB_BUFSZ];
	logic [AW-1:0]   wr_ptr_q;
	logic [AW-1:0]   rd_ptr_q;
	logic [CW-1:0]   count_q;
	logic            pop;

	assign pop = pop_valid_o && pop_ready_i;

	assign pop_valid_o = (count_q != '0);
	assign pop_data_o  = mem_q[rd_ptr_q]; // Head word, shown before the pop.
	assign free_o      = DEPTH - count_q;

	always_ff @(posedge clk_i) begin
		if (push_valid_i)
			mem_q[wr_ptr_q] <= push_data_i;
	end

	always_ff @(posedge clk_i) begin
		if (vga_rst_o) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_valid_i)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			count_q <= count_q + CW'(push_valid_i) - CW'(pop);
		end
	end

	// The fetcher's credit check must keep pushes off a full buffer.
	a_no_overflow: assert property (@(posedge clk_i) disable iff (vga_rst_o)
		!(push_valid_i && count_q == DEPTH));
endmodule

// ==== src/frame_fetcher.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reads pixel words from memory and pushes them to the FIFO.
// Restarts at the source address after each full frame.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

`include "fbdev_defines.svh"

module frame_fetcher (
	input  logic                    clk_i,
	input  logic                    vga_rst_o,
	input  logic [`FB_ADDR_W-1:0]   src_addr_i,
	output fbdev_pkg::pi_op_e       m_op_o,
	output logic [`FB_ADDR_W-1:0]   m_addr_o,
	input  logic [31:0]             m_data_i,
	input  logic                    m_rdy_i,
	input  logic [`FB_FREE_W-1:0]   free_i,
	output logic                    push_valid_o,
	output fbdev_pkg::px_word_t     push_data_o
);
	import fbdev_pkg::*;

	localparam px_cnt_t PX_FRAME = px_cnt_t'(`FB_WIDTH * `FB_HEIGHT);
	// A returning word can hold up to 256 pixels.
	localparam px_cnt_t PX_TAIL  = PX_FRAME - px_cnt_t'(256);

	logic                    run_q;
	logic                    acc_q;  // Read accepted last cycle, data now.
	logic [`FB_ADDR_W-1:0]   addr_q;
	px_cnt_t                 px_sum_q;
	px_cnt_t                 px_sum_next;
	px_word_t                ret_word;
	logic                    credit;
	logic                    near_end;
	logic                    issue;
	logic                    accept;
	logic                    frame_done;

	assign ret_word    = px_word_t'(m_data_i);
	assign px_sum_next = px_sum_q + px_cnt_t'(ret_word.rpt) + px_cnt_t'(1);
	assign frame_done  = acc_q && (px_sum_next >= PX_FRAME);

	// Keep one FIFO slot for each read whose data is still to come.
	assign credit   = (free_i > {{(`FB_FREE_W-1){1'b0}}, acc_q});
	// Near the frame end, wait for the last word before the next read.
	assign near_end = (px_sum_q >= PX_TAIL);
	assign issue    = run_q && credit && !(near_end && acc_q);
	assign accept   = issue && m_rdy_i;

	assign m_op_o       = issue ? PIRDOP : PINOOP;
	assign m_addr_o     = addr_q;
	assign push_valid_o = acc_q;
	assign push_data_o  = ret_word;

	always_ff @(posedge clk_i) begin
		if (vga_rst_o) begin
			run_q    <= 1'b0;
			acc_q    <= 1'b0;
			px_sum_q <= '0;
		end else begin
			run_q <= 1'b1;
			acc_q <= accept;
			if (frame_done)
				px_sum_q <= '0;
			else if (acc_q)
				px_sum_q <= px_sum_next;
		end
	end

	// Loaded while idle, so the first read uses the new source.
	always_ff @(posedge clk_i) begin
		if (!run_q || frame_done)
			addr_q <= src_addr_i;
		else if (accept)
			addr_q <= addr_q + 1'b1;
	end

	a_addr_hold: assert property (@(posedge clk_i) disable iff (vga_rst_o)
		(m_op_o == PIRDOP && !m_rdy_i) |=> (m_op_o == PIRDOP && $stable(m_addr_o)));
endmodule

// ==== src/pixel_expander.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expands run-length words into pixels on the VGA outputs.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pixel_expander (
	input  logic                 clk_i,
	input  logic                 vga_rst_o,
	vid_timing_if.sink           tim,
	input  logic                 pop_valid_i,
	output logic                 pop_ready_o,
	input  fbdev_pkg::px_word_t  pop_data_i,
	output logic [7:0]           vga_red_o,
	output logic [7:0]           vga_green_o,
	output logic [7:0]           vga_blue_o,
	output logic                 vga_blank_o,
	output logic                 vga_hsync_o,
	output logic                 vga_vsync_o,
	output logic                 underrun_o
);
	logic       en_q;
	logic [7:0] rpt_q;
	logic       underrun_q;
	logic       show;
	logic       rpt_done;
	logic [7:0] red_q;
	logic [7:0] green_q;
	logic [7:0] blue_q;

	assign show     = en_q && tim.active;
	assign rpt_done = (rpt_q == pop_data_i.rpt);

	// Last repeat, or last pixel of the frame.
	assign pop_ready_o = show && (rpt_done || tim.frame_end);

	always_ff @(posedge clk_i) begin
		if (vga_rst_o) begin
			en_q       <= 1'b0;
			rpt_q      <= '0;
			underrun_q <= 1'b0;
		end else begin
			if (tim.vblank)
				en_q <= 1'b1; // Start on a frame boundary.
			if (show && pop_valid_i)
				rpt_q <= pop_ready_o ? 8'd0 : rpt_q + 8'd1;
			if (show && !pop_valid_i)
				underrun_q <= 1'b1;
		end
	end

	// Same edge as blank_q, so colour lines up with blank.
	always_ff @(posedge clk_i) begin
		if (vga_rst_o || !(show && pop_valid_i)) begin
			red_q   <= '0;
			green_q <= '0;
			blue_q  <= '0;
		end else begin
			red_q   <= pop_data_i.red;
			green_q <= pop_data_i.green;
			blue_q  <= pop_data_i.blue;
		end
	end

	assign vga_red_o   = red_q;
	assign vga_green_o = green_q;
	assign vga_blue_o  = blue_q;
	assign vga_blank_o = tim.blank_q;
	assign vga_hsync_o = tim.sync_q[0];
	assign vga_vsync_o = tim.sync_q[1];
	assign underrun_o  = underrun_q;
endmodule

// ==== src/fb_cmd_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host command decoder, source address and display reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

`include "fbdev_defines.svh"

module fb_cmd_regs (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  fbdev_pkg::pi_op_e       s_op_i,
	input  logic [31:0]             s_data_i,
	output logic [31:0]             s_data_o,
	output logic [`FB_ADDR_W-1:0]   src_addr_o,
	output logic                    vga_rst_o
);
	import fbdev_pkg::*;

	logic [`FB_ADDR_W-1:0] src_q;
	logic [31:0]           reply_q;
	logic [31:0]           info;
	cmd_e                  cmd;
	getinfo_e              sel;

	assign cmd = cmd_e'(s_data_i[1:0]);
	assign sel = getinfo_e'(s_data_i[31:2]);

	always_comb begin
		case (sel)
			GETINFO_WIDTH:  info = 32'(`FB_WIDTH);
			GETINFO_HEIGHT: info = 32'(`FB_HEIGHT);
			GETINFO_HZ:     info = 32'(`FB_REFRESH);
			GETINFO_BUFCNT: info = 32'(`FB_BUFCNT);
			default:        info = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i)
			src_q <= '1; // Display off.
		else if (s_op_i == PIRWOP && cmd == CMDSRCSET)
			src_q <= s_data_i[31:2];
	end

	// Reply holds until the next command.
	always_ff @(posedge clk_i) begin
		if (s_op_i == PIRWOP) begin
			case (cmd)
				CMDSRCSET:  reply_q <= 32'd4;
				CMDGETINFO: reply_q <= info;
				default:    reply_q <= '0;
			endcase
		end
	end

	assign s_data_o   = reply_q;
	assign src_addr_o = src_q;
	assign vga_rst_o  = rst_i || (&src_q);
endmodule

// ==== src/fbdev_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Framebuffer display controller top level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

`include "fbdev_defines.svh"

module fbdev_top (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  fbdev_pkg::pi_op_e       s_op_i,
	input  logic [31:0]             s_data_i,
	output logic [31:0]             s_data_o,
	output logic                    s_rdy_o,
	output fbdev_pkg::pi_op_e       m_op_o,
	output logic [`FB_ADDR_W-1:0]   m_addr_o,
	input  logic [31:0]             m_data_i,
	input  logic                    m_rdy_i,
	output logic [7:0]              vga_red_o,
	output logic [7:0]              vga_green_o,
	output logic [7:0]              vga_blue_o,
	output logic                    vga_blank_o,
	output logic                    vga_hsync_o,
	output logic                    vga_vsync_o,
	output logic                    vga_rst_o,
	output logic                    underrun_o
);
	import fbdev_pkg::*;

	logic [`FB_ADDR_W-1:0] src_addr;
	logic                  push_valid;
	px_word_t              push_data;
	logic [`FB_FREE_W-1:0] free;
	logic                  pop_valid;
	logic                  pop_ready;
	px_word_t              pop_data;

	vid_timing_if tim_if ();

	assign s_rdy_o = 1'b1; // Commands never stall.

	fb_cmd_regs cmd_regs_i (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.s_op_i     (s_op_i),
		.s_data_i   (s_data_i),
		.s_data_o   (s_data_o),
		.src_addr_o (src_addr),
		.vga_rst_o  (vga_rst_o)
	);

	video_timing timing_i (
		.clk_i     (clk_i),
		.vga_rst_o (vga_rst_o),
		.tim       (tim_if.source)
	);

	frame_fetcher fetcher_i (
		.clk_i        (clk_i),
		.vga_rst_o    (vga_rst_o),
		.src_addr_i   (src_addr),
		.m_op_o       (m_op_o),
		.m_addr_o     (m_addr_o),
		.m_data_i     (m_data_i),
		.m_rdy_i      (m_rdy_i),
		.free_i       (free),
		.push_valid_o (push_valid),
		.push_data_o  (push_data)
	);

	pixel_fifo fifo_i (
		.clk_i        (clk_i),
		.vga_rst_o    (vga_rst_o),
		.push_valid_i (push_valid),
		.push_data_i  (push_data),
		.free_o       (free),
		.pop_valid_o  (pop_valid),
		.pop_ready_i  (pop_ready),
		.pop_data_o   (pop_data)
	);

	pixel_expander expander_i (
		.clk_i       (clk_i),
		.vga_rst_o   (vga_rst_o),
		.tim         (tim_if.sink),
		.pop_valid_i (pop_valid),
		.pop_ready_o (pop_ready),
		.pop_data_i  (pop_data),
		.vga_red_o   (vga_red_o),
		.vga_green_o (vga_green_o),
		.vga_blue_o  (vga_blue_o),
		.vga_blank_o (vga_blank_o),
		.vga_hsync_o (vga_hsync_o),
		.vga_vsync_o (vga_vsync_o),
		.underrun_o  (underrun_o)
	);
endmodule

// ==== testbench/fbdev_mem_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipelined read memory holding one run-length coded frame.
// Answers one cycle after acceptance, with random ready stalls.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

`include "fbdev_defines.svh"

module fbdev_mem_model #(
	parameter logic [`FB_ADDR_W-1:0] BASE = '0
) (
	input  logic                    clk_i,
	input  fbdev_pkg::pi_op_e       m_op_i,
	input  logic [`FB_ADDR_W-1:0]   m_addr_i,
	output logic [31:0]             m_data_o,
	output logic                    m_rdy_o
);
	import fbdev_pkg::*;

	localparam int FRAME_PX = `FB_WIDTH * `FB_HEIGHT;
	localparam int IMG_MAX  = FRAME_PX / 2; // Each word covers 2 pixels or more.

	logic [31:0]           img [IMG_MAX];
	int                    img_len;
	logic [31:0]           rng_q;
	logic                  stall_q;
	logic                  take;
	logic [`FB_ADDR_W-1:0] take_addr;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Words up to and including the one that completes the frame.
	initial begin : build_image
		int       sum;
		px_word_t w;
		rng_q   = 32'd57390;
		sum     = 0;
		img_len = 0;
		while (sum < FRAME_PX) begin
			rng_q = xorshift(rng_q);
			w.rpt = 8'(32'd1 + rng_q % 32'd7);
			{w.blue, w.green, w.red} = 24'(img_len) ^ 24'hA5C33C;
			img[img_len] = w;
			sum = sum + int'(w.rpt) + 1;
			img_len = img_len + 1;
		end
		m_data_o = '0;
		m_rdy_o  = 1'b0;
		stall_q  = 1'b0;
		take     = 1'b0;
		take_addr = '0;
	end

	// Request seen mid-cycle, once the DUT outputs have settled.
	always @(negedge clk_i) begin
		take      <= (m_op_i == PIRDOP) && m_rdy_o;
		take_addr <= m_addr_i;
	end

	always @(posedge clk_i) begin
		#1;
		m_data_o = take ? img[int'(take_addr - BASE)] : 32'h0;
		rng_q    = xorshift(rng_q);
		stall_q  = !stall_q && rng_q[3]; // Never two stalls in a row.
		m_rdy_o  = !stall_q;
	end
endmodule

// ==== testbench/fbdev_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the framebuffer controller: host commands,
// then three frames of raster, colour and bus checks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

`include "fbdev_defines.svh"

module fbdev_tb;
	import fbdev_pkg::*;

	localparam logic [`FB_ADDR_W-1:0] SRC_ADDR = 30'h0001_0000;
	localparam int CMD_N = 7;

	typedef struct packed {
		logic [31:0] cmd;
		logic [31:0] reply;
		logic        rst;   // Expected vga_rst_o after the command.
	} cmd_entry_t;

	logic                  clk_i;
	logic                  rst_i;
	pi_op_e                s_op_i;
	logic [31:0]           s_data_i;
	logic [31:0]           s_data_o;
	logic                  s_rdy_o;
	pi_op_e                m_op_o;
	logic [`FB_ADDR_W-1:0] m_addr_o;
	logic [31:0]           m_data_i;
	logic                  m_rdy_i;
	logic [7:0]            vga_red_o;
	logic [7:0]            vga_green_o;
	logic [7:0]            vga_blue_o;
	logic                  vga_blank_o;
	logic                  vga_hsync_o;
	logic                  vga_vsync_o;
	logic                  vga_rst_o;
	logic                  underrun_o;
	cmd_entry_t            cmd_tab [CMD_N];
	int                    errors;

	fbdev_top dut_i (.*);

	fbdev_mem_model #(.BASE(SRC_ADDR)) mem_i (
		.clk_i    (clk_i),
		.m_op_i   (m_op_o),
		.m_addr_i (m_addr_o),
		.m_data_o (m_data_i),
		.m_rdy_o  (m_rdy_i)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	task automatic abort_run();
		errors = errors + 1;
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_px(input string name, input px_word_t got, input px_word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_op(input string name, input pi_op_e got, input pi_op_e exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input logic [`FB_ADDR_W-1:0] got,
			input logic [`FB_ADDR_W-1:0] lo, input logic [`FB_ADDR_W-1:0] hi);
		if (got < lo || got > hi) begin
			$display("CHECK FAILED m_addr_o: got %h, allowed %h to %h", got, lo, hi);
			abort_run();
		end
	endtask

	task automatic wait_display_on();
		int n;
		n = 0;
		while (vga_rst_o) begin
			@(negedge clk_i);
			n = n + 1;
			if (n > 20) begin
				$display("Timeout: vga_rst_o did not fall after the source address was set");
				abort_run();
			end
		end
	endtask

	// Outputs at each mid-cycle show the position of the cycle before.
	task automatic scan_frames();
		int                    h;
		int                    v;
		int                    frame;
		int                    w;
		int                    c;
		px_word_t              cur;
		px_word_t              exp_px;
		px_word_t              got_px;
		logic [`FB_ADDR_W-1:0] hi;
		h = 0;
		v = 0;
		frame = 0;
		w = 0;
		c = 0;
		hi = SRC_ADDR + `FB_ADDR_W'(mem_i.img_len - 1);
		for (int k = 0; k < 3 * `FB_H_MAX * `FB_V_MAX; k++) begin
			@(negedge clk_i);
			check_bit("vga_blank_o", vga_blank_o, h >= `FB_WIDTH || v >= `FB_HEIGHT);
			check_bit("vga_hsync_o", vga_hsync_o, h >= `FB_H_SYNC_START && h < `FB_H_SYNC_END);
			check_bit("vga_vsync_o", vga_vsync_o, v >= `FB_V_SYNC_START && v < `FB_V_SYNC_END);
			check_bit("underrun_o", underrun_o, 1'b0);
			exp_px = '0;
			if (frame > 0 && h < `FB_WIDTH && v < `FB_HEIGHT) begin
				if (h == 0 && v == 0) begin
					w = 0;
					c = 0;
				end
				cur = mem_i.img[w];
				exp_px = cur;
				exp_px.rpt = 8'h00;
				c = c + 1;
				if (c == int'(cur.rpt) + 1) begin
					w = w + 1;
					c = 0;
				end
			end
			got_px = {8'h00, vga_blue_o, vga_green_o, vga_red_o};
			check_px("{vga_blue_o, vga_green_o, vga_red_o}", got_px, exp_px);
			if (m_op_o == PIRDOP)
				check_addr(m_addr_o, SRC_ADDR, hi);
			h = h + 1;
			if (h == `FB_H_MAX) begin
				h = 0;
				v = v + 1;
				if (v == `FB_V_MAX) begin
					v = 0;
					frame = frame + 1;
				end
			end
		end
	endtask

	initial begin
		errors   = 0;
		rst_i    = 1'b1;
		s_op_i   = PINOOP;
		s_data_i = '0;
		cmd_tab[0] = {{GETINFO_WIDTH, CMDGETINFO}, 32'(`FB_WIDTH), 1'b1};
		cmd_tab[1] = {{GETINFO_HEIGHT, CMDGETINFO}, 32'(`FB_HEIGHT), 1'b1};
		cmd_tab[2] = {{GETINFO_HZ, CMDGETINFO}, 32'(`FB_REFRESH), 1'b1};
		cmd_tab[3] = {{GETINFO_BUFCNT, CMDGETINFO}, 32'(`FB_BUFCNT), 1'b1};
		cmd_tab[4] = {{30'd9, CMDGETINFO}, 32'd0, 1'b1}; // Unknown selector.
		cmd_tab[5] = {{30'h3FFF_FFFF, CMDSRCSET}, 32'd4, 1'b1};
		cmd_tab[6] = {{SRC_ADDR, CMDSRCSET}, 32'd4, 1'b0};
		repeat (8) @(posedge clk_i);
		#1 rst_i = 1'b0;
		@(negedge clk_i);
		check_bit("vga_rst_o", vga_rst_o, 1'b1);
		for (int i = 0; i < CMD_N; i++) begin
			@(posedge clk_i);
			#1;
			s_op_i   = PIRWOP;
			s_data_i = cmd_tab[i].cmd;
			@(posedge clk_i);
			#1;
			s_op_i   = PINOOP;
			s_data_i = '0;
			@(negedge clk_i);
			check_bit("s_rdy_o", s_rdy_o, 1'b1);
			check_word("s_data_o", s_data_o, cmd_tab[i].reply);
			check_bit("vga_rst_o", vga_rst_o, cmd_tab[i].rst);
			if (cmd_tab[i].rst) begin
				check_bit("vga_blank_o", vga_blank_o, 1'b0);
				check_bit("vga_hsync_o", vga_hsync_o, 1'b0);
				check_bit("vga_vsync_o", vga_vsync_o, 1'b0);
				check_op("m_op_o", m_op_o, PINOOP);
				check_px("{vga_blue_o, vga_green_o, vga_red_o}",
					{8'h00, vga_blue_o, vga_green_o, vga_red_o}, '0);
			end
		end
		wait_display_on();
		scan_frames();
		if (errors == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "errors found");
		end
	end
endmodule

// ==== fbdev.f ====
+incdir+src
src/fbdev_pkg.sv
src/vid_timing_if.sv
src/video_timing.sv
src/pixel_fifo.sv
src/frame_fetcher.sv
src/pixel_expander.sv
src/fb_cmd_regs.sv
src/fbdev_top.sv
testbench/fbdev_mem_model.sv
testbench/fbdev_tb.sv
